/* source/proc_ci_config.svh */
`ifndef PROC_CI_CONFIG_SVH
`define PROC_CI_CONFIG_SVH

// System clock in Hz
`define PROC_CI_CLK_FREQ 25000000

// UART bit rate
`define PROC_CI_BIT_RATE 3125000

// Clocks per UART bit, 8 at the rates above
`define PROC_CI_CLKS_PER_BIT (`PROC_CI_CLK_FREQ / `PROC_CI_BIT_RATE)

// Program memory depth in 32-bit words
`define PROC_CI_MEM_WORDS 256

// Answer to a ping, "PCI1" in ASCII
`define PROC_CI_ID 32'h50434931

// Core reset stretch after a release order
`define PROC_CI_CORE_RST_CYCLES 20

`endif

/* source/proc_ci_pkg.sv */
`default_nettype none

`include "proc_ci_config.svh"

package proc_ci_pkg;

  // UART payload
  typedef logic [7:0] byte_t;

  // Memory and core bus data
  typedef logic [31:0] word_t;

  // Word address into the program memory
  typedef logic [$clog2(`PROC_CI_MEM_WORDS)-1:0] addr_t;

  // Host command codes
  typedef enum logic [7:0] {
    CMD_PING  = 8'h70,
    CMD_WRITE = 8'h57,
    CMD_READ  = 8'h52,
    CMD_GO    = 8'h47,
    CMD_HALT  = 8'h48
  } cmd_e;

  // Controller FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_MEM,
    ST_SEND,
    ST_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

/* source/baud_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "proc_ci_config.svh"

module baud_timer (
  input  logic clk,
  input  logic rst_n_i,
  input  logic run_i,
  output logic bit_tick_o,
  output logic half_tick_o
);

  localparam int CLKS_PER_BIT = `PROC_CI_CLKS_PER_BIT;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

  logic [CNT_W-1:0] cnt_q;

  // Count restarts from zero whenever run_i drops
  always_ff @(posedge clk) begin
    if (!rst_n_i || !run_i) begin
      cnt_q <= '0;
    end else if (bit_tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Last clock of a bit period
  assign bit_tick_o  = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));
  assign half_tick_o = (cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               rx_i,
  output proc_ci_pkg::byte_t byte_o,
  output logic               valid_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e          state_q;
  logic [1:0]         sync_q;
  logic               rx_prev_q;
  logic [2:0]         bit_cnt_q;
  proc_ci_pkg::byte_t shift_q;
  logic               rx_s;
  logic               timer_run;
  logic               bit_tick;
  logic               half_tick;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
    end
  end

  assign rx_s = sync_q[1];

  // Timer restarts at mid start bit so later ticks land mid-bit
  assign timer_run = (state_q != RX_IDLE) && !(state_q == RX_START && half_tick);

  baud_timer u_baud_timer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .run_i       (timer_run),
    .bit_tick_o  (bit_tick),
    .half_tick_o (half_tick)
  );

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
      valid_o   <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (rx_prev_q && !rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Glitch shorter than half a bit is dropped
          if (half_tick) begin
            bit_cnt_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            valid_o <= rx_s;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_tick) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign byte_o = shift_q;

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  logic               clk,
  input  logic               rst_n_i,
  input  proc_ci_pkg::byte_t byte_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               tx_o
);

  logic [9:0] frame_q;
  logic [3:0] bit_cnt_q;
  logic       bit_tick;

  baud_timer u_baud_timer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .run_i       (busy_o),
    .bit_tick_o  (bit_tick),
    .half_tick_o ()
  );

  // Busy covers start bit, 8 data bits and stop bit
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_o    <= 1'b0;
      bit_cnt_q <= '0;
    end else if (!busy_o) begin
      if (start_i) begin
        busy_o    <= 1'b1;
        bit_cnt_q <= '0;
      end
    end else if (bit_tick) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (bit_cnt_q == 4'd9) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Frame is stop, data, start; bit 0 goes out first
  always_ff @(posedge clk) begin
    if (start_i && !busy_o) begin
      frame_q <= {1'b1, byte_i, 1'b0};
    end else if (busy_o && bit_tick) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  assign tx_o = busy_o ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

/* source/reset_boot_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "proc_ci_config.svh"

module reset_boot_timer (
  input  logic clk,
  input  logic rst_n_i,
  input  logic go_i,
  input  logic halt_i,
  output logic rst_core_o
);

  localparam int CYCLES = `PROC_CI_CORE_RST_CYCLES;
  localparam int CNT_W  = $clog2(CYCLES);

  logic [CNT_W-1:0] cnt_q;
  logic             counting_q;
  logic             running_q;

  // Core leaves reset CYCLES clocks after the go strobe
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      counting_q <= 1'b0;
      running_q  <= 1'b0;
    end else if (go_i) begin
      cnt_q      <= CNT_W'(CYCLES - 1);
      counting_q <= 1'b1;
      running_q  <= 1'b0;
    end else if (halt_i) begin
      counting_q <= 1'b0;
      running_q  <= 1'b0;
    end else if (counting_q) begin
      cnt_q <= cnt_q - 1'b1;
      // Counter hits zero on this edge
      if (cnt_q == CNT_W'(1)) begin
        counting_q <= 1'b0;
        running_q  <= 1'b1;
      end
    end
  end

  assign rst_core_o = !running_q;

endmodule

`default_nettype wire

/* source/ci_controller_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "proc_ci_config.svh"

module ci_controller_fsm (
  input  logic               clk,
  input  logic               rst_n_i,
  input  proc_ci_pkg::byte_t rx_byte_i,
  input  logic               rx_valid_i,
  output proc_ci_pkg::byte_t tx_byte_o,
  output logic               tx_start_o,
  input  logic               tx_busy_i,
  output logic               go_o,
  output logic               halt_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output proc_ci_pkg::addr_t mem_addr_o,
  output proc_ci_pkg::word_t mem_wdata_o,
  input  proc_ci_pkg::word_t mem_rdata_i
);

  proc_ci_pkg::ctrl_state_e state_q;
  proc_ci_pkg::cmd_e        cmd_q;
  proc_ci_pkg::addr_t       addr_q;
  proc_ci_pkg::word_t       word_q;
  logic [1:0]               byte_cnt_q;
  logic                     rd_pend_q;
  logic                     tx_free;
  logic                     ping_hit;

  // Busy only rises the cycle after the start strobe
  assign tx_free  = !tx_busy_i && !tx_start_o;
  assign ping_hit = (state_q == proc_ci_pkg::ST_IDLE) && rx_valid_i &&
                    (rx_byte_i == proc_ci_pkg::CMD_PING);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= proc_ci_pkg::ST_IDLE;
      cmd_q      <= proc_ci_pkg::CMD_PING;
      byte_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
      tx_start_o <= 1'b0;
      go_o       <= 1'b0;
      halt_o     <= 1'b0;
    end else begin
      tx_start_o <= 1'b0;
      go_o       <= 1'b0;
      halt_o     <= 1'b0;
      rd_pend_q  <= (state_q == proc_ci_pkg::ST_MEM) && (cmd_q == proc_ci_pkg::CMD_READ);
      case (state_q)
        proc_ci_pkg::ST_IDLE: begin
          if (rx_valid_i) begin
            byte_cnt_q <= '0;
            case (rx_byte_i)
              proc_ci_pkg::CMD_PING: state_q <= proc_ci_pkg::ST_WAIT;
              proc_ci_pkg::CMD_WRITE, proc_ci_pkg::CMD_READ: begin
                cmd_q   <= proc_ci_pkg::cmd_e'(rx_byte_i);
                state_q <= proc_ci_pkg::ST_ADDR;
              end
              proc_ci_pkg::CMD_GO:   go_o   <= 1'b1;
              proc_ci_pkg::CMD_HALT: halt_o <= 1'b1;
              // Unknown codes are dropped
              default: state_q <= proc_ci_pkg::ST_IDLE;
            endcase
          end
        end
        proc_ci_pkg::ST_ADDR: begin
          if (rx_valid_i) begin
            state_q <= (cmd_q == proc_ci_pkg::CMD_WRITE) ? proc_ci_pkg::ST_DATA
                                                         : proc_ci_pkg::ST_MEM;
          end
        end
        proc_ci_pkg::ST_DATA: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              state_q <= proc_ci_pkg::ST_MEM;
            end
          end
        end
        proc_ci_pkg::ST_MEM: begin
          state_q <= (cmd_q == proc_ci_pkg::CMD_READ) ? proc_ci_pkg::ST_WAIT
                                                      : proc_ci_pkg::ST_IDLE;
        end
        proc_ci_pkg::ST_WAIT: begin
          if (tx_free) begin
            state_q <= proc_ci_pkg::ST_SEND;
          end
        end
        proc_ci_pkg::ST_SEND: begin
          tx_start_o <= 1'b1;
          byte_cnt_q <= byte_cnt_q + 1'b1;
          state_q    <= (byte_cnt_q == 2'd3) ? proc_ci_pkg::ST_IDLE : proc_ci_pkg::ST_WAIT;
        end
        default: state_q <= proc_ci_pkg::ST_IDLE;
      endcase
    end
  end

  // Word register collects write data and serializes answers, LSB first
  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      word_q <= mem_rdata_i;
    end else if (ping_hit) begin
      word_q <= `PROC_CI_ID;
    end else if (state_q == proc_ci_pkg::ST_DATA && rx_valid_i) begin
      word_q <= {rx_byte_i, word_q[31:8]};
    end else if (state_q == proc_ci_pkg::ST_SEND) begin
      word_q <= {8'h00, word_q[31:8]};
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == proc_ci_pkg::ST_ADDR && rx_valid_i) begin
      addr_q <= proc_ci_pkg::addr_t'(rx_byte_i);
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == proc_ci_pkg::ST_SEND) begin
      tx_byte_o <= word_q[7:0];
    end
  end

  // One access per command, held for a single cycle in ST_MEM
  assign mem_req_o   = (state_q == proc_ci_pkg::ST_MEM);
  assign mem_we_o    = (cmd_q == proc_ci_pkg::CMD_WRITE);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = word_q;

endmodule

`default_nettype wire

/* source/ci_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "proc_ci_config.svh"

module ci_memory (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               rst_core_i,
  input  logic               ctl_req_i,
  input  logic               ctl_we_i,
  input  proc_ci_pkg::addr_t ctl_addr_i,
  input  proc_ci_pkg::word_t ctl_wdata_i,
  output proc_ci_pkg::word_t ctl_rdata_o,
  input  logic               core_cyc_i,
  input  logic               core_we_i,
  input  proc_ci_pkg::addr_t core_addr_i,
  input  proc_ci_pkg::word_t core_data_i,
  output proc_ci_pkg::word_t core_data_o,
  output logic               core_ack_o
);

  localparam int WORDS = `PROC_CI_MEM_WORDS;

  proc_ci_pkg::word_t mem_q [WORDS];
  proc_ci_pkg::word_t rdata_q;
  proc_ci_pkg::addr_t acc_addr;
  proc_ci_pkg::word_t acc_wdata;
  logic               acc_en;
  logic               acc_we;
  logic               ack_q;

  // Controller owns the port while the core is held in reset
  assign acc_en    = rst_core_i ? ctl_req_i   : core_cyc_i;
  assign acc_we    = rst_core_i ? ctl_we_i    : core_we_i;
  assign acc_addr  = rst_core_i ? ctl_addr_i  : core_addr_i;
  assign acc_wdata = rst_core_i ? ctl_wdata_i : core_data_i;

  always_ff @(posedge clk) begin
    if (acc_en) begin
      if (acc_we) begin
        mem_q[acc_addr] <= acc_wdata;
      end
      rdata_q <= mem_q[acc_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= core_cyc_i && !rst_core_i;
    end
  end

  // No ack reaches a core that has just been halted
  assign core_ack_o  = ack_q && !rst_core_i;
  assign core_data_o = rdata_q;
  assign ctl_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/proc_ci_top.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_ci_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               rx_i,
  output logic               tx_o,
  output logic               rst_core_o,
  input  logic               core_cyc_i,
  input  logic               core_we_i,
  input  proc_ci_pkg::addr_t core_addr_i,
  input  proc_ci_pkg::word_t core_data_i,
  output proc_ci_pkg::word_t core_data_o,
  output logic               core_ack_o
);

  proc_ci_pkg::byte_t rx_byte;
  logic               rx_valid;
  proc_ci_pkg::byte_t tx_byte;
  logic               tx_start;
  logic               tx_busy;
  logic               go;
  logic               halt;
  logic               ctl_req;
  logic               ctl_we;
  proc_ci_pkg::addr_t ctl_addr;
  proc_ci_pkg::word_t ctl_wdata;
  proc_ci_pkg::word_t ctl_rdata;

  uart_rx u_uart_rx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rx_i    (rx_i),
    .byte_o  (rx_byte),
    .valid_o (rx_valid)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .byte_i  (tx_byte),
    .start_i (tx_start),
    .busy_o  (tx_busy),
    .tx_o    (tx_o)
  );

  // Host command parser
  ci_controller_fsm u_ci_controller_fsm (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_byte_i   (rx_byte),
    .rx_valid_i  (rx_valid),
    .tx_byte_o   (tx_byte),
    .tx_start_o  (tx_start),
    .tx_busy_i   (tx_busy),
    .go_o        (go),
    .halt_o      (halt),
    .mem_req_o   (ctl_req),
    .mem_we_o    (ctl_we),
    .mem_addr_o  (ctl_addr),
    .mem_wdata_o (ctl_wdata),
    .mem_rdata_i (ctl_rdata)
  );

  reset_boot_timer u_reset_boot_timer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .go_i       (go),
    .halt_i     (halt),
    .rst_core_o (rst_core_o)
  );

  // Program memory shared with the external core
  ci_memory u_ci_memory (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rst_core_i  (rst_core_o),
    .ctl_req_i   (ctl_req),
    .ctl_we_i    (ctl_we),
    .ctl_addr_i  (ctl_addr),
    .ctl_wdata_i (ctl_wdata),
    .ctl_rdata_o (ctl_rdata),
    .core_cyc_i  (core_cyc_i),
    .core_we_i   (core_we_i),
    .core_addr_i (core_addr_i),
    .core_data_i (core_data_i),
    .core_data_o (core_data_o),
    .core_ack_o  (core_ack_o)
  );

endmodule

`default_nettype wire

/* dv/proc_ci_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_ci_checker (
  input logic clk,
  input logic rst_n_i,
  input logic tx_i,
  input logic rst_core_i,
  input logic core_cyc_i,
  input logic core_ack_i
);

  // Core held in reset never sees an ack
  ack_in_core_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(core_ack_i && rst_core_i))
    else $error("core_ack_o high while rst_core_o is high");

  // Ack answers a request served one cycle earlier
  ack_after_request: assert property (@(posedge clk) disable iff (!rst_n_i)
    core_ack_i |-> $past(core_cyc_i && !rst_core_i))
    else $error("core_ack_o high without a served request in the previous cycle");

  // Line idles high while the harness is in reset
  tx_idle_in_reset: assert property (@(posedge clk)
    (!rst_n_i && $past(!rst_n_i)) |-> tx_i)
    else $error("tx_o low during reset");

endmodule

`default_nettype wire

/* dv/proc_ci_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "proc_ci_config.svh"

module proc_ci_tb;

  localparam int CLKS_PER_BIT = `PROC_CI_CLKS_PER_BIT;
  localparam int RESET_CYCLES = 16;
  localparam int N_WORDS      = 16;
  // Ping, writes, reads, go, halt and the final read
  localparam int UART_BYTES   = 5 + N_WORDS * 6 + N_WORDS * 6 + 2 + 6;
  localparam int CORE_CYCLES  = N_WORDS + 16;
  localparam int RST_WAIT     = 4 * (`PROC_CI_CORE_RST_CYCLES + CLKS_PER_BIT);
  localparam int WATCHDOG_CYCLES = 2 * (UART_BYTES * 10 * CLKS_PER_BIT + CORE_CYCLES +
                                        `PROC_CI_CORE_RST_CYCLES + RESET_CYCLES);

  logic               clk;
  logic               rst_n_i;
  logic               rx_i;
  logic               tx_o;
  logic               rst_core_o;
  logic               core_cyc_i;
  logic               core_we_i;
  proc_ci_pkg::addr_t core_addr_i;
  proc_ci_pkg::word_t core_data_i;
  proc_ci_pkg::word_t core_data_o;
  logic               core_ack_o;

  proc_ci_pkg::word_t model [`PROC_CI_MEM_WORDS];
  proc_ci_pkg::addr_t wr_addr [N_WORDS];
  int                 seed;
  logic               mon_en = 1'b0;
  logic               exp_ack = 1'b0;
  logic               exp_rd = 1'b0;
  proc_ci_pkg::word_t exp_data;

  proc_ci_top proc_ci_top_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .rst_core_o  (rst_core_o),
    .core_cyc_i  (core_cyc_i),
    .core_we_i   (core_we_i),
    .core_addr_i (core_addr_i),
    .core_data_i (core_data_i),
    .core_data_o (core_data_o),
    .core_ack_o  (core_ack_o)
  );

  bind proc_ci_top proc_ci_checker u_proc_ci_checker (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tx_i       (tx_o),
    .rst_core_i (rst_core_o),
    .core_cyc_i (core_cyc_i),
    .core_ack_i (core_ack_o)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic proc_ci_pkg::word_t ref_read(input proc_ci_pkg::addr_t addr);
    return model[addr];
  endfunction

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic compare_word(input string name, input proc_ci_pkg::word_t exp,
                              input proc_ci_pkg::word_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_byte(input string name, input proc_ci_pkg::byte_t exp,
                              input proc_ci_pkg::byte_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      fail_run();
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input proc_ci_pkg::byte_t data);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rx_i <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic recv_byte(output proc_ci_pkg::byte_t data);
    int i;
    @(posedge clk);
    while (tx_o !== 1'b0) @(posedge clk);
    // Move to the middle of the start bit
    repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
    compare_level("uart start bit", 1'b0, tx_o);
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data[i] = tx_o;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    compare_level("uart stop bit", 1'b1, tx_o);
  endtask

  task automatic host_write(input proc_ci_pkg::addr_t addr, input proc_ci_pkg::word_t data);
    int i;
    send_byte(proc_ci_pkg::CMD_WRITE);
    send_byte(addr);
    for (i = 0; i < 4; i++) begin
      send_byte(data[8*i +: 8]);
    end
  endtask

  task automatic host_read(input proc_ci_pkg::addr_t addr, output proc_ci_pkg::word_t data);
    proc_ci_pkg::byte_t b;
    int                 i;
    send_byte(proc_ci_pkg::CMD_READ);
    send_byte(addr);
    for (i = 0; i < 4; i++) begin
      recv_byte(b);
      data[8*i +: 8] = b;
    end
  endtask

  task automatic wait_core_reset(input logic level, input string name);
    int n;
    n = 0;
    while (rst_core_o !== level && n < RST_WAIT) begin
      @(posedge clk);
      n++;
    end
    compare_level(name, level, rst_core_o);
  endtask

  // Core bus response checked against the request seen one edge earlier
  always @(posedge clk) begin
    if (mon_en) begin
      compare_level("core ack", exp_ack, core_ack_o);
      if (exp_ack && exp_rd) begin
        compare_word("core read data", exp_data, core_data_o);
      end
    end
    exp_ack  = rst_n_i && core_cyc_i && !rst_core_o;
    exp_rd   = !core_we_i;
    exp_data = ref_read(core_addr_i);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
    fail_run();
  end

  initial begin
    proc_ci_pkg::word_t id;
    proc_ci_pkg::word_t data_w;
    proc_ci_pkg::byte_t data_b;
    int                 i;
    int                 k;
    seed = 32'h3304;
    rst_n_i     <= 1'b0;
    rx_i        <= 1'b1;
    core_cyc_i  <= 1'b0;
    core_we_i   <= 1'b0;
    core_addr_i <= '0;
    core_data_i <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    mon_en  <= 1'b1;
    @(posedge clk);
    compare_level("reset tx_o", 1'b1, tx_o);
    compare_level("reset rst_core_o", 1'b1, rst_core_o);
    compare_level("reset core_ack_o", 1'b0, core_ack_o);

    id = `PROC_CI_ID;
    send_byte(proc_ci_pkg::CMD_PING);
    for (i = 0; i < 4; i++) begin
      recv_byte(data_b);
      compare_byte("ping id byte", id[8*i +: 8], data_b);
    end

    for (k = 0; k < N_WORDS; k++) begin
      wr_addr[k] = proc_ci_pkg::addr_t'($random(seed));
      data_w     = $random(seed);
      host_write(wr_addr[k], data_w);
      model[wr_addr[k]] = data_w;
    end
    for (k = 0; k < N_WORDS; k++) begin
      host_read(wr_addr[k], data_w);
      compare_word("host read after write", ref_read(wr_addr[k]), data_w);
    end

    // Release the core, then stream reads back to back
    send_byte(proc_ci_pkg::CMD_GO);
    wait_core_reset(1'b0, "core release after go");
    for (k = 0; k < N_WORDS; k++) begin
      core_cyc_i  <= 1'b1;
      core_we_i   <= 1'b0;
      core_addr_i <= wr_addr[k];
      @(posedge clk);
    end
    data_w = $random(seed);
    core_we_i   <= 1'b1;
    core_addr_i <= wr_addr[0];
    core_data_i <= data_w;
    @(posedge clk);
    core_cyc_i <= 1'b0;
    core_we_i  <= 1'b0;
    repeat (2) @(posedge clk);
    model[wr_addr[0]] = data_w;

    // Halted core gets no ack and the host sees the core's write
    send_byte(proc_ci_pkg::CMD_HALT);
    wait_core_reset(1'b1, "core reset after halt");
    core_cyc_i <= 1'b1;
    repeat (4) @(posedge clk);
    core_cyc_i <= 1'b0;
    host_read(wr_addr[0], data_w);
    compare_word("host read of core write", ref_read(wr_addr[0]), data_w);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* proc_ci.f */
+incdir+source
source/proc_ci_pkg.sv
source/baud_timer.sv
source/uart_rx.sv
source/uart_tx.sv
source/reset_boot_timer.sv
source/ci_controller_fsm.sv
source/ci_memory.sv
source/proc_ci_top.sv
dv/proc_ci_checker.sv
dv/proc_ci_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the proc_ci testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module proc_ci_tb -o proc_ci_sim -f proc_ci.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/proc_ci_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
